/* hw/audio_pkg.sv */
////////////////////////////////////////
// Audio sample definitions
// Sample and card source widths, plus the
// 32-bit I2S stereo frame with its raw and
// per-channel views
////////////////////////////////////////

package audio_pkg;

    // Output and ESP32 sample width
    localparam int SAMPLE_WIDTH = 16;

    // Card sources are widened to this before summing
    localparam int CORE_WIDTH = 13;

    // SuperSprite and Mockingboard level width
    localparam int SOURCE_WIDTH = 10;

    // Shift that places a 10-bit level at the top of CORE_WIDTH
    localparam int SOURCE_SHIFT = 3;

    // One I2S frame as seen by the receiver and the mixer
    // The receiver fills it as a plain shift word, the mixer
    // reads the two channels out of it
    typedef union packed {
        logic [2*SAMPLE_WIDTH-1:0] raw;    // Serial order, MSB first
        struct packed {
            logic [SAMPLE_WIDTH-1:0] left;   // Slots 0 to 15
            logic [SAMPLE_WIDTH-1:0] right;  // Slots 16 to 31
        } sample;
    } i2s_frame_u;

endpackage

/* hw/timing_pkg.sv */
////////////////////////////////////////
// Audio timing constants
// Logic clock and frame rates, slot counts
// and the bit-clock divider they imply
////////////////////////////////////////

package timing_pkg;

    localparam int CLOCK_SPEED_HZ = 54_000_000;  // Logic clock
    localparam int AUDIO_RATE = 44_100;          // Stereo frames per second

    localparam int SLOTS_PER_FRAME = 32;    // Bit slots in one stereo frame
    localparam int SLOTS_PER_CHANNEL = 16;  // Bit slots per channel

    // Bit-clock half periods per second
    localparam int BCLK_HALF_RATE = AUDIO_RATE * SLOTS_PER_FRAME * 2;

    // Logic cycles per bit-clock half period, rounded to nearest
    localparam int BCLK_DIV_DEFAULT =
        (CLOCK_SPEED_HZ + BCLK_HALF_RATE / 2) / BCLK_HALF_RATE;

endpackage

/* hw/i2s_timing.sv */
////////////////////////////////////////
// I2S timing generator
// Bit clock and word select towards the
// ESP32, with shift and load strobes for
// the receiver
////////////////////////////////////////

`timescale 1ns/1ps

module i2s_timing #(
    parameter int BCLK_DIV = timing_pkg::BCLK_DIV_DEFAULT
) (
    input  logic clk_logic_w,
    input  logic system_reset_n_w,

    output logic i2s_bclk_o,
    output logic i2s_lrclk_o,
    output logic shift_strobe_o,
    output logic load_strobe_o
);

    localparam int DIV_W = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
    localparam int SLOT_W = $clog2(timing_pkg::SLOTS_PER_FRAME);

    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(timing_pkg::SLOTS_PER_FRAME - 1);
    // Word select high from the last left slot up to the slot before the last one
    localparam logic [SLOT_W-1:0] LR_FIRST = SLOT_W'(timing_pkg::SLOTS_PER_CHANNEL - 1);
    localparam logic [SLOT_W-1:0] LR_LAST = SLOT_W'(timing_pkg::SLOTS_PER_FRAME - 2);

    logic [DIV_W-1:0]  div_cnt_r;
    logic [SLOT_W-1:0] slot_r;
    logic              bclk_r;
    logic              lrclk_r;
    logic              load_strobe_r;

    wire               half_done_w = (div_cnt_r == DIV_W'(BCLK_DIV - 1));
    wire [SLOT_W-1:0]  slot_next_w = slot_r + 1'b1;

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            div_cnt_r     <= '0;
            slot_r        <= '0;
            bclk_r        <= 1'b0;
            lrclk_r       <= 1'b0;
            load_strobe_r <= 1'b0;
        end else begin
            load_strobe_r <= shift_strobe_o && (slot_r == LAST_SLOT);  // After last bit
            if (half_done_w) begin
                div_cnt_r <= '0;
                bclk_r    <= ~bclk_r;
                if (bclk_r) begin  // Falling edge starts the next slot
                    slot_r  <= slot_next_w;
                    // Decoded from the slot about to begin
                    lrclk_r <= (slot_next_w >= LR_FIRST) && (slot_next_w <= LR_LAST);
                end
            end else begin
                div_cnt_r <= div_cnt_r + 1'b1;
            end
        end
    end

    // Rising bit-clock edge, data from the ESP32 is stable here
    assign shift_strobe_o = half_done_w && !bclk_r;
    assign load_strobe_o  = load_strobe_r;
    assign i2s_bclk_o     = bclk_r;
    assign i2s_lrclk_o    = lrclk_r;

    // Receiver relies on shift and load never landing in one cycle
    strobes_exclusive_a: assert property (
        @(posedge clk_logic_w) disable iff (!system_reset_n_w)
        !(shift_strobe_o && load_strobe_o)
    );

endmodule

/* hw/i2s_receiver.sv */
////////////////////////////////////////
// I2S receiver
// Shifts in the ESP32 serial stream and
// latches one stereo frame per load strobe
////////////////////////////////////////

`timescale 1ns/1ps

module i2s_receiver (
    input  logic                   clk_logic_w,
    input  logic                   system_reset_n_w,

    input  logic                   i2s_data_i,
    input  logic                   shift_strobe_i,
    input  logic                   load_strobe_i,

    output audio_pkg::i2s_frame_u  frame_o,
    output logic                   frame_valid_o
);

    localparam int FRAME_W = $bits(audio_pkg::i2s_frame_u);

    logic [FRAME_W-1:0]     shift_r;       // Serial bits, oldest at the top
    audio_pkg::i2s_frame_u  frame_r;
    logic                   frame_valid_r;

    // Shift word, MSB of the left sample arrives first
    always_ff @(posedge clk_logic_w) begin
        if (shift_strobe_i) begin
            shift_r <= {shift_r[FRAME_W-2:0], i2s_data_i};
        end
    end

    // Completed frame, held until the next load
    always_ff @(posedge clk_logic_w) begin
        if (load_strobe_i) begin
            frame_r.raw <= shift_r;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            frame_valid_r <= 1'b0;
        end else begin
            frame_valid_r <= load_strobe_i;  // One pulse per frame
        end
    end

    assign frame_o       = frame_r;
    assign frame_valid_o = frame_valid_r;

    // A stretched pulse would make the mixer register one frame twice
    frame_valid_pulse_a: assert property (
        @(posedge clk_logic_w) disable iff (!system_reset_n_w)
        frame_valid_o |=> !frame_valid_o
    );

endmodule

/* hw/audio_mixer.sv */
////////////////////////////////////////
// Audio mixer
// Widens the card sources, sums them per
// channel, adds the ESP32 samples and
// registers one stereo sample per frame
////////////////////////////////////////

`timescale 1ns/1ps

module audio_mixer #(
    parameter bit ESP32_AUDIO_ENABLE = 1'b1
) (
    input  logic                                clk_logic_w,
    input  logic                                system_reset_n_w,

    input  logic                                speaker_i,
    input  logic [audio_pkg::SOURCE_WIDTH-1:0]  ssp_audio_i,
    input  logic [audio_pkg::SOURCE_WIDTH-1:0]  mb_audio_l_i,
    input  logic [audio_pkg::SOURCE_WIDTH-1:0]  mb_audio_r_i,

    input  audio_pkg::i2s_frame_u               frame_i,
    input  logic                                frame_valid_i,

    output logic [audio_pkg::SAMPLE_WIDTH-1:0]  audio_l_o,
    output logic [audio_pkg::SAMPLE_WIDTH-1:0]  audio_r_o,
    output logic                                audio_valid_o
);

    localparam int CW = audio_pkg::CORE_WIDTH;
    localparam int SW = audio_pkg::SAMPLE_WIDTH;

    // Sum of three widened sources plus one ESP32 sample wraps at 2^16
    function automatic logic [SW-1:0] mix(input logic [CW-1:0] a,
                                          input logic [CW-1:0] b,
                                          input logic [CW-1:0] c,
                                          input logic [SW-1:0] esp);
        logic [SW-1:0] core;
        core = SW'(a) + SW'(b) + SW'(c);  // Cannot overflow at 13 bits each
        return core + esp;
    endfunction

    // Speaker drives the top bit and levels are moved up to the top
    wire [CW-1:0] speaker_ext_w = {speaker_i, {(CW-1){1'b0}}};
    wire [CW-1:0] ssp_ext_w     = {ssp_audio_i, {audio_pkg::SOURCE_SHIFT{1'b0}}};
    wire [CW-1:0] mb_l_ext_w    = {mb_audio_l_i, {audio_pkg::SOURCE_SHIFT{1'b0}}};
    wire [CW-1:0] mb_r_ext_w    = {mb_audio_r_i, {audio_pkg::SOURCE_SHIFT{1'b0}}};

    wire [SW-1:0] esp_l_w = ESP32_AUDIO_ENABLE ? frame_i.sample.left : '0;
    wire [SW-1:0] esp_r_w = ESP32_AUDIO_ENABLE ? frame_i.sample.right : '0;

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            audio_l_o     <= '0;
            audio_r_o     <= '0;
            audio_valid_o <= 1'b0;
        end else begin
            audio_valid_o <= frame_valid_i;
            if (frame_valid_i) begin  // Card levels sampled here once per frame
                audio_l_o <= mix(speaker_ext_w, ssp_ext_w, mb_l_ext_w, esp_l_w);
                audio_r_o <= mix(speaker_ext_w, ssp_ext_w, mb_r_ext_w, esp_r_w);
            end
        end
    end

    // One output sample per received frame and never held over
    audio_valid_pulse_a: assert property (
        @(posedge clk_logic_w) disable iff (!system_reset_n_w)
        audio_valid_o |=> !audio_valid_o
    );

endmodule

/* hw/audio_path_top.sv */
////////////////////////////////////////
// Audio path top level
// I2S timing, receiver and mixer between
// the card sources, the ESP32 and the
// stereo sample output
////////////////////////////////////////

`timescale 1ns/1ps

module audio_path_top #(
    parameter int BCLK_DIV           = timing_pkg::BCLK_DIV_DEFAULT,
    parameter bit ESP32_AUDIO_ENABLE = 1'b1
) (
    input  logic                                clk_logic_w,
    input  logic                                system_reset_n_w,

    input  logic                                speaker_i,
    input  logic [audio_pkg::SOURCE_WIDTH-1:0]  ssp_audio_i,
    input  logic [audio_pkg::SOURCE_WIDTH-1:0]  mb_audio_l_i,
    input  logic [audio_pkg::SOURCE_WIDTH-1:0]  mb_audio_r_i,

    output logic                                i2s_bclk_o,
    output logic                                i2s_lrclk_o,
    input  logic                                i2s_data_i,

    output logic [audio_pkg::SAMPLE_WIDTH-1:0]  audio_l_o,
    output logic [audio_pkg::SAMPLE_WIDTH-1:0]  audio_r_o,
    output logic                                audio_valid_o
);

    logic                   shift_strobe_w;
    logic                   load_strobe_w;
    audio_pkg::i2s_frame_u  frame_w;
    logic                   frame_valid_w;

    i2s_timing #(
        .BCLK_DIV(BCLK_DIV)
    ) i2s_timing (
        .clk_logic_w     (clk_logic_w),
        .system_reset_n_w(system_reset_n_w),
        .i2s_bclk_o      (i2s_bclk_o),
        .i2s_lrclk_o     (i2s_lrclk_o),
        .shift_strobe_o  (shift_strobe_w),
        .load_strobe_o   (load_strobe_w)
    );

    i2s_receiver i2s_receiver (
        .clk_logic_w     (clk_logic_w),
        .system_reset_n_w(system_reset_n_w),
        .i2s_data_i      (i2s_data_i),
        .shift_strobe_i  (shift_strobe_w),
        .load_strobe_i   (load_strobe_w),
        .frame_o         (frame_w),
        .frame_valid_o   (frame_valid_w)
    );

    audio_mixer #(
        .ESP32_AUDIO_ENABLE(ESP32_AUDIO_ENABLE)
    ) audio_mixer (
        .clk_logic_w     (clk_logic_w),
        .system_reset_n_w(system_reset_n_w),
        .speaker_i       (speaker_i),
        .ssp_audio_i     (ssp_audio_i),
        .mb_audio_l_i    (mb_audio_l_i),
        .mb_audio_r_i    (mb_audio_r_i),
        .frame_i         (frame_w),
        .frame_valid_i   (frame_valid_w),
        .audio_l_o       (audio_l_o),
        .audio_r_o       (audio_r_o),
        .audio_valid_o   (audio_valid_o)
    );

endmodule

/* dv/audio_path_tb.sv */
////////////////////////////////////////
// Audio path testbench
// Models the ESP32 serial stream, drives
// card sources per frame from a case file
// and checks word select and mixed output
////////////////////////////////////////

`timescale 1ns/1ps

module audio_path_tb;

    localparam int BCLK_DIV = 4;
    localparam int MAX_CASES = 64;
    localparam int MAX_WORDS = MAX_CASES * 8;  // Eight columns per case
    localparam string CASES_FILE = "dv/audio_path_cases.txt";

    logic clk_logic_w = 1'b0;
    logic system_reset_n_w = 1'b0;
    logic speaker_i = 1'b0;
    logic [audio_pkg::SOURCE_WIDTH-1:0] ssp_audio_i = '0;
    logic [audio_pkg::SOURCE_WIDTH-1:0] mb_audio_l_i = '0;
    logic [audio_pkg::SOURCE_WIDTH-1:0] mb_audio_r_i = '0;
    logic i2s_data_i = 1'b0;
    logic i2s_bclk_o;
    logic i2s_lrclk_o;
    logic [audio_pkg::SAMPLE_WIDTH-1:0] audio_l_o;
    logic [audio_pkg::SAMPLE_WIDTH-1:0] audio_r_o;
    logic audio_valid_o;

    logic [19:0] case_words [0:MAX_WORDS-1];  // Top nibble set marks an unused word
    int num_cases = 0;
    int value_errors = 0;
    int other_errors = 0;
    int pulse_count = 0;
    int frame_count = 0;
    int slot_count = 0;
    int cycle_count = 0;
    int timeout_limit = 0;
    logic bclk_seen = 1'b0;

    // Inputs and expected outputs of the frame in flight
    logic cur_speaker = 1'b0;
    logic [audio_pkg::SOURCE_WIDTH-1:0] cur_ssp = '0;
    logic [audio_pkg::SOURCE_WIDTH-1:0] cur_mb_l = '0;
    logic [audio_pkg::SOURCE_WIDTH-1:0] cur_mb_r = '0;
    logic [audio_pkg::SAMPLE_WIDTH-1:0] cur_i2s_l = '0;
    logic [audio_pkg::SAMPLE_WIDTH-1:0] cur_i2s_r = '0;
    logic [audio_pkg::SAMPLE_WIDTH-1:0] exp_l = '0;
    logic [audio_pkg::SAMPLE_WIDTH-1:0] exp_r = '0;

    audio_path_top #(
        .BCLK_DIV(BCLK_DIV),
        .ESP32_AUDIO_ENABLE(1'b1)
    ) dut (
        .clk_logic_w(clk_logic_w),
        .system_reset_n_w(system_reset_n_w),
        .speaker_i(speaker_i),
        .ssp_audio_i(ssp_audio_i),
        .mb_audio_l_i(mb_audio_l_i),
        .mb_audio_r_i(mb_audio_r_i),
        .i2s_bclk_o(i2s_bclk_o),
        .i2s_lrclk_o(i2s_lrclk_o),
        .i2s_data_i(i2s_data_i),
        .audio_l_o(audio_l_o),
        .audio_r_o(audio_r_o),
        .audio_valid_o(audio_valid_o)
    );

    initial begin
        forever #2 clk_logic_w = ~clk_logic_w;  // 4 ns period
    end

    always @(posedge clk_logic_w) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_sample(input string name,
                                input logic [audio_pkg::SAMPLE_WIDTH-1:0] got,
                                input logic [audio_pkg::SAMPLE_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h (frame %0d)",
                     name, got, exp, frame_count);
            value_errors++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h (frame %0d, slot %0d)",
                     name, got, exp, frame_count, slot_count);
            value_errors++;
        end
    endtask

    // Slot k carries bit 15 - (k mod 16), left channel first
    function automatic logic slot_bit(input logic [audio_pkg::SAMPLE_WIDTH-1:0] left,
                                      input logic [audio_pkg::SAMPLE_WIDTH-1:0] right,
                                      input int slot);
        if (slot < 16) begin
            return left[15-slot];
        end
        return right[31-slot];
    endfunction

    task automatic read_cases();
        int i;
        int words;
        for (i = 0; i < MAX_WORDS; i++) begin
            case_words[i] = {4'hF, 16'(i)};
        end
        $readmemh(CASES_FILE, case_words);
        words = 0;
        while (words < MAX_WORDS && case_words[words][19:16] == 4'h0) begin
            words++;
        end
        if (words == 0 || words % 8 != 0) begin
            $display("Case file held %0d values, not a whole number of cases", words);
            other_errors++;
        end
        num_cases = words / 8;
    endtask

    // Frame 0 is a silent lead-in, frame n carries case n-1
    task automatic load_frame(input int frame);
        int base;
        if (frame == 0 || frame > num_cases) begin
            cur_speaker = 1'b0;
            cur_ssp = '0;
            cur_mb_l = '0;
            cur_mb_r = '0;
            cur_i2s_l = '0;
            cur_i2s_r = '0;
            exp_l = '0;
            exp_r = '0;
        end else begin
            base = (frame - 1) * 8;
            cur_speaker = case_words[base][0];
            cur_ssp = case_words[base+1][audio_pkg::SOURCE_WIDTH-1:0];
            cur_mb_l = case_words[base+2][audio_pkg::SOURCE_WIDTH-1:0];
            cur_mb_r = case_words[base+3][audio_pkg::SOURCE_WIDTH-1:0];
            cur_i2s_l = case_words[base+4][15:0];
            cur_i2s_r = case_words[base+5][15:0];
            exp_l = case_words[base+6][15:0];
            exp_r = case_words[base+7][15:0];
        end
    endtask

    // ESP32 model and card sources, slot and frame come from the monitor
    always @(posedge clk_logic_w) begin
        speaker_i <= cur_speaker;
        ssp_audio_i <= cur_ssp;
        mb_audio_l_i <= cur_mb_l;
        mb_audio_r_i <= cur_mb_r;
        i2s_data_i <= slot_bit(cur_i2s_l, cur_i2s_r, slot_count);
    end

    // Outputs are read half a cycle after the DUT updates them
    always @(negedge clk_logic_w) begin
        if (system_reset_n_w) begin
            if (audio_valid_o === 1'b1) begin  // Result of the frame now ending
                if (pulse_count != frame_count) begin
                    $display("audio_valid_o pulse %0d arrived during frame %0d",
                             pulse_count, frame_count);
                    other_errors++;
                end
                check_sample("audio_l_o", audio_l_o, exp_l);
                check_sample("audio_r_o", audio_r_o, exp_r);
                pulse_count++;
            end
            if (bclk_seen && !i2s_bclk_o) begin  // Bit clock fell, next slot
                slot_count = (slot_count + 1) % 32;
                if (slot_count == 0) begin
                    frame_count++;
                    load_frame(frame_count);
                end
                check_level("i2s_lrclk_o", i2s_lrclk_o, slot_count >= 15 && slot_count <= 30);
            end
            bclk_seen = i2s_bclk_o;
        end
    end

    initial begin
        read_cases();
        load_frame(0);
        timeout_limit = (num_cases + 2) * 32 * 2 * BCLK_DIV * 2;
        repeat (3) @(posedge clk_logic_w);
        system_reset_n_w <= 1'b1;

        @(negedge clk_logic_w);  // State left by reset
        check_level("i2s_bclk_o", i2s_bclk_o, 1'b0);
        check_level("i2s_lrclk_o", i2s_lrclk_o, 1'b0);
        check_level("audio_valid_o", audio_valid_o, 1'b0);
        check_sample("audio_l_o", audio_l_o, '0);
        check_sample("audio_r_o", audio_r_o, '0);

        while (pulse_count < num_cases + 1 && cycle_count < timeout_limit) begin
            @(posedge clk_logic_w);
        end
        if (pulse_count < num_cases + 1) begin
            $display("audio_valid_o stopped arriving: %0d of %0d pulses after %0d cycles",
                     pulse_count, num_cases + 1, cycle_count);
            other_errors++;
        end

        $display("Done: %0d cases, %0d pulses, %0d value errors, %0d other errors",
                 num_cases, pulse_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* audio_path_top.f */
hw/audio_pkg.sv
hw/timing_pkg.sv
hw/i2s_timing.sv
hw/i2s_receiver.sv
hw/audio_mixer.sv
hw/audio_path_top.sv
dv/audio_path_tb.sv

/* Bender.yml */
package:
  name: audio_path

dependencies: {}

sources:
  # Packages first, then the pipeline stages and the top level
  - hw/audio_pkg.sv
  - hw/timing_pkg.sv
  - hw/i2s_timing.sv
  - hw/i2s_receiver.sv
  - hw/audio_mixer.sv
  - hw/audio_path_top.sv

  # Simulation only
  - target: test
    files:
      - dv/audio_path_tb.sv

/* dv/audio_path_cases.txt */
// Columns: speaker ssp mb_l mb_r i2s_l i2s_r exp_l exp_r, all hex
// Each line is one frame, sent after one leading silent frame
// Silence, then single card sources
0 000 000 000 0000 0000 0000 0000
1 000 000 000 0000 0000 1000 1000
0 001 000 000 0000 0000 0008 0008
0 000 001 000 0000 0000 0008 0000
0 000 000 001 0000 0000 0000 0008
0 3ff 000 000 0000 0000 1ff8 1ff8
0 000 3ff 200 0000 0000 1ff8 1000
1 3ff 3ff 3ff 0000 0000 4ff0 4ff0
0 155 2aa 0ff 0000 0000 1ff8 12a0
0 000 000 000 1234 0000 1234 0000
0 000 000 000 0000 5678 0000 5678
0 000 000 000 8000 ffff 8000 ffff
0 000 000 000 7fff 8001 7fff 8001
0 000 000 000 fedc 0123 fedc 0123
1 3ff 3ff 3ff ffff ffff 4fef 4fef
1 000 000 000 f000 f800 0000 0800
0 3ff 000 3ff e010 0001 0008 3ff1
0 100 080 040 0005 fffb 0c05 09fb
1 200 1ff 001 b000 c000 dff8 e008
1 3ff 3ff 3ff b010 b010 0000 0000
0 000 000 000 0000 0000 0000 0000
